// File: verilog/npc_pkg.sv
`default_nettype none

package npc_pkg;

  localparam int XLEN       = 32;
  localparam int INST_W     = 32;
  localparam int REG_AW     = 5;
  localparam int IMEM_DEPTH = 256;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

  localparam logic [XLEN-1:0] PC_INIT = '0;

  // RV32I base opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASSB
  } alu_op_e;

  // JUMP covers jal and jalr
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP
  } br_op_e;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    logic              wb_en;
    alu_op_e           alu_op;
    br_op_e            br_op;
    logic              is_jalr;
    logic              is_ebreak;
  } dec_t;

endpackage

`default_nettype wire

// File: verilog/npc_if.sv
`default_nettype none

// Fetched instruction, IFU to IDU
interface fetch_if import npc_pkg::*; ();
  logic              valid;
  logic              ready;
  logic [XLEN-1:0]   pc;
  logic [INST_W-1:0] inst;

  modport src (output valid, pc, inst, input ready);
  modport dst (input valid, pc, inst, output ready);
endinterface

// Decoded instruction, IDU to EXU
interface exec_if import npc_pkg::*; ();
  logic valid;
  logic ready;
  dec_t dec;

  modport src (output valid, dec, input ready);
  modport dst (input valid, dec, output ready);
endinterface

// Combinational register file read
interface regread_if import npc_pkg::*; ();
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   data1;
  logic [XLEN-1:0]   data2;

  modport req (output rs1, rs2, input data1, data2);
  modport rsp (input rs1, rs2, output data1, data2);
endinterface

`default_nettype wire

// File: verilog/npc_pc.sv
`default_nettype none

module npc_pc import npc_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            retire_i,
  input  logic [XLEN-1:0] next_pc_i,
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;

  // Next address already resolved by the EXU
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= PC_INIT;
    end else if (retire_i) begin
      pc_q <= next_pc_i;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: verilog/npc_regfile.sv
`default_nettype none

module npc_regfile import npc_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              retire_i,
  input  logic              wb_en_i,
  input  logic [REG_AW-1:0] rd_i,
  input  logic [XLEN-1:0]   wdata_i,
  regread_if.rsp            rd_port
);

  logic [XLEN-1:0] regs [2 ** REG_AW];

  // x0 is never written and keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2 ** REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (retire_i && wb_en_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rd_port.data1 = regs[rd_port.rs1];
  assign rd_port.data2 = regs[rd_port.rs2];

endmodule

`default_nettype wire

// File: verilog/npc_ifu.sv
`default_nettype none

module npc_ifu import npc_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [XLEN-1:0]    pc_i,
  input  logic               retire_i,
  input  logic               halt_i,
  input  logic               imem_we_i,
  input  logic [IMEM_AW-1:0] imem_addr_i,
  input  logic [INST_W-1:0]  imem_wdata_i,
  fetch_if.src               out
);

  logic [INST_W-1:0] imem [IMEM_DEPTH];

  logic              pending_q;
  logic              valid_q;
  logic [INST_W-1:0] inst_q;
  logic [XLEN-1:0]   pc_q;
  logic              slot_free;
  logic              fetch;

  assign slot_free = !valid_q || out.ready;
  assign fetch     = pending_q && slot_free;

  // Load port and registered word read
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_wdata_i;
    end
    if (fetch) begin
      inst_q <= imem[pc_i[IMEM_AW+1:2]];
      pc_q   <= pc_i;
    end
  end

  // One fetch out of reset, then one per retire
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b1;
      valid_q   <= 1'b0;
    end else begin
      if (fetch) begin
        pending_q <= 1'b0;
        valid_q   <= 1'b1;
      end else if (out.ready) begin
        valid_q <= 1'b0;
      end
      if (retire_i && !halt_i) begin
        pending_q <= 1'b1;
      end
    end
  end

  assign out.valid = valid_q;
  assign out.inst  = inst_q;
  assign out.pc    = pc_q;

endmodule

`default_nettype wire

// File: verilog/npc_idu.sv
`default_nettype none

module npc_idu import npc_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  fetch_if.dst   in,
  regread_if.req rf,
  exec_if.src    out
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  dec_t            dec;
  dec_t            dec_q;
  logic            valid_q;

  // funct3 to ALU op; SUB only exists in the register form
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                      input logic is_reg);
    case (f3)
      3'b000:  alu_sel = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  assign opcode = in.inst[6:0];
  assign funct3 = in.inst[14:12];
  assign funct7 = in.inst[31:25];

  assign imm_i = {{20{in.inst[31]}}, in.inst[31:20]};
  assign imm_u = {in.inst[31:12], 12'b0};
  assign imm_b = {{20{in.inst[31]}}, in.inst[7], in.inst[30:25], in.inst[11:8], 1'b0};
  assign imm_j = {{12{in.inst[31]}}, in.inst[19:12], in.inst[20], in.inst[30:21], 1'b0};

  assign rf.rs1 = in.inst[19:15];
  assign rf.rs2 = in.inst[24:20];

  always_comb begin
    dec        = '0;
    dec.pc     = in.pc;
    dec.op1    = rf.data1;
    dec.op2    = rf.data2;
    dec.rd     = in.inst[11:7];
    dec.alu_op = ALU_ADD;
    dec.br_op  = BR_NONE;
    case (opcode)
      OPC_OP: begin
        dec.wb_en  = 1'b1;
        dec.alu_op = alu_sel(funct3, funct7[5], 1'b1);
      end
      OPC_OP_IMM: begin
        dec.wb_en  = 1'b1;
        dec.op2    = imm_i;
        dec.alu_op = alu_sel(funct3, funct7[5], 1'b0);
      end
      OPC_LUI: begin
        dec.wb_en  = 1'b1;
        dec.op2    = imm_u;
        dec.alu_op = ALU_PASSB;
      end
      OPC_AUIPC: begin
        dec.wb_en = 1'b1;
        dec.op1   = in.pc;
        dec.op2   = imm_u;
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_op = BR_EQ;
          3'b001:  dec.br_op = BR_NE;
          3'b100:  dec.br_op = BR_LT;
          3'b101:  dec.br_op = BR_GE;
          3'b110:  dec.br_op = BR_LTU;
          3'b111:  dec.br_op = BR_GEU;
          default: dec.br_op = BR_NONE;
        endcase
      end
      OPC_JAL: begin
        dec.wb_en = 1'b1;
        dec.imm   = imm_j;
        dec.br_op = BR_JUMP;
      end
      OPC_JALR: begin
        dec.wb_en   = 1'b1;
        dec.imm     = imm_i;
        dec.br_op   = BR_JUMP;
        dec.is_jalr = 1'b1;
      end
      OPC_SYSTEM: begin
        // ecall and others fall through as no-ops
        dec.is_ebreak = (funct3 == 3'b000) && (in.inst[31:20] == 12'h001);
      end
      default: begin
        dec.wb_en = 1'b0;
      end
    endcase
  end

  assign in.ready = !valid_q || out.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in.valid && in.ready) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      dec_q <= dec;
    end
  end

  assign out.valid = valid_q;
  assign out.dec   = dec_q;

endmodule

`default_nettype wire

// File: verilog/npc_exu.sv
`default_nettype none

module npc_exu import npc_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  exec_if.dst               in,
  output logic              retire_o,
  output logic              wb_en_o,
  output logic [REG_AW-1:0] rd_o,
  output logic [XLEN-1:0]   wb_data_o,
  output logic [XLEN-1:0]   next_pc_o,
  output logic              halt_o
);

  dec_t            d;
  logic [XLEN-1:0] alu_res;
  logic            taken;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] jalr_tgt;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] wb_data;
  logic            fire;
  logic            retire_q;
  logic            wb_en_q;
  logic            halt_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN-1:0] wb_data_q;
  logic [XLEN-1:0] next_pc_q;

  assign d = in.dec;

  always_comb begin
    case (d.alu_op)
      ALU_SUB:   alu_res = d.op1 - d.op2;
      ALU_AND:   alu_res = d.op1 & d.op2;
      ALU_OR:    alu_res = d.op1 | d.op2;
      ALU_XOR:   alu_res = d.op1 ^ d.op2;
      ALU_SLL:   alu_res = d.op1 << d.op2[4:0];
      ALU_SRL:   alu_res = d.op1 >> d.op2[4:0];
      ALU_SRA:   alu_res = $unsigned($signed(d.op1) >>> d.op2[4:0]);
      ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(d.op1) < $signed(d.op2)};
      ALU_SLTU:  alu_res = {{(XLEN-1){1'b0}}, d.op1 < d.op2};
      ALU_PASSB: alu_res = d.op2;
      default:   alu_res = d.op1 + d.op2;
    endcase
  end

  always_comb begin
    case (d.br_op)
      BR_EQ:   taken = d.op1 == d.op2;
      BR_NE:   taken = d.op1 != d.op2;
      BR_LT:   taken = $signed(d.op1) < $signed(d.op2);
      BR_GE:   taken = $signed(d.op1) >= $signed(d.op2);
      BR_LTU:  taken = d.op1 < d.op2;
      BR_GEU:  taken = d.op1 >= d.op2;
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign seq_pc   = d.pc + 32'd4;
  assign jalr_tgt = (d.op1 + d.imm) & ~32'd1;
  assign next_pc  = d.is_jalr ? jalr_tgt : (taken ? d.pc + d.imm : seq_pc);
  // Link address for jal and jalr
  assign wb_data  = (d.br_op == BR_JUMP) ? seq_pc : alu_res;

  // Nothing is accepted once halted
  assign in.ready = !halt_q;
  assign fire     = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_q <= 1'b0;
      wb_en_q  <= 1'b0;
      halt_q   <= 1'b0;
    end else begin
      retire_q <= fire;
      wb_en_q  <= fire && d.wb_en;
      halt_q   <= halt_q || (fire && d.is_ebreak);
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      rd_q      <= d.rd;
      wb_data_q <= wb_data;
      next_pc_q <= next_pc;
    end
  end

  assign retire_o  = retire_q;
  assign wb_en_o   = wb_en_q;
  assign rd_o      = rd_q;
  assign wb_data_o = wb_data_q;
  assign next_pc_o = next_pc_q;
  assign halt_o    = halt_q;

endmodule

`default_nettype wire

// File: verilog/npc_top.sv
`default_nettype none

module npc_top import npc_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               imem_we_i,
  input  logic [IMEM_AW-1:0] imem_addr_i,
  input  logic [INST_W-1:0]  imem_wdata_i,
  output logic               retire_o,
  output logic [XLEN-1:0]    retire_pc_o,
  output logic               wb_en_o,
  output logic [REG_AW-1:0]  wb_addr_o,
  output logic [XLEN-1:0]    wb_data_o,
  output logic               halt_o
);

  logic [XLEN-1:0]   pc;
  logic              retire;
  logic              wb_en;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   wb_data;
  logic [XLEN-1:0]   next_pc;
  logic              halt;

  fetch_if   fetch_bus ();
  exec_if    exec_bus ();
  regread_if rr_bus ();

  npc_pc pc_u (
    .clk       (clk),
    .rst       (rst),
    .retire_i  (retire),
    .next_pc_i (next_pc),
    .pc_o      (pc)
  );

  npc_regfile regfile_u (
    .clk      (clk),
    .rst      (rst),
    .retire_i (retire),
    .wb_en_i  (wb_en),
    .rd_i     (rd),
    .wdata_i  (wb_data),
    .rd_port  (rr_bus.rsp)
  );

  npc_ifu ifu_u (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .retire_i     (retire),
    .halt_i       (halt),
    .imem_we_i    (imem_we_i),
    .imem_addr_i  (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .out          (fetch_bus.src)
  );

  npc_idu idu_u (
    .clk (clk),
    .rst (rst),
    .in  (fetch_bus.dst),
    .rf  (rr_bus.req),
    .out (exec_bus.src)
  );

  npc_exu exu_u (
    .clk       (clk),
    .rst       (rst),
    .in        (exec_bus.dst),
    .retire_o  (retire),
    .wb_en_o   (wb_en),
    .rd_o      (rd),
    .wb_data_o (wb_data),
    .next_pc_o (next_pc),
    .halt_o    (halt)
  );

  // PC still holds the retiring address until the next edge
  assign retire_o    = retire;
  assign retire_pc_o = pc;
  assign wb_en_o     = wb_en;
  assign wb_addr_o   = rd;
  assign wb_data_o   = wb_data;
  assign halt_o      = halt;

endmodule

`default_nettype wire

// File: testbench/npc_tb.sv
`default_nettype none

module npc_tb import npc_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int HALT_WAIT    = 20;
  localparam int RUNS         = 7;
  // Static instruction count over all programs
  localparam int TOTAL_INSTS  = 138;
  localparam int TIMEOUT_CYCLES = TOTAL_INSTS * 4 + TOTAL_INSTS + (RUNS + 1) * RESET_CYCLES
                                  + HALT_WAIT + 200;

  localparam logic [INST_W-1:0] EBREAK = 32'h0010_0073;

  // Order add sub and or xor sll srl sra slt sltu from the low bits
  localparam logic [29:0] OP_F3  = {3'b011, 3'b010, 3'b101, 3'b101, 3'b001,
                                    3'b100, 3'b110, 3'b111, 3'b000, 3'b000};
  localparam logic [9:0]  OP_ALT = 10'b0010000010;
  // addi slti sltiu xori ori andi
  localparam logic [17:0] IMM_F3 = {3'b111, 3'b110, 3'b100, 3'b011, 3'b010, 3'b000};

  logic               clk;
  logic               rst;
  logic               imem_we_i;
  logic [IMEM_AW-1:0] imem_addr_i;
  logic [INST_W-1:0]  imem_wdata_i;
  logic               retire_o;
  logic [XLEN-1:0]    retire_pc_o;
  logic               wb_en_o;
  logic [REG_AW-1:0]  wb_addr_o;
  logic [XLEN-1:0]    wb_data_o;
  logic               halt_o;

  int checks = 0;
  int errors = 0;
  int cycle_count = 0;

  logic [31:0]       lcg_state = 32'hbfa0;
  logic [INST_W-1:0] prog_q [$];
  logic [INST_W-1:0] prog_mem [IMEM_DEPTH];
  logic [XLEN-1:0]   model_regs [32];
  logic [XLEN-1:0]   model_pc;
  logic              model_halted;

  npc_top npc_top_i (
    .clk          (clk),
    .rst          (rst),
    .imem_we_i    (imem_we_i),
    .imem_addr_i  (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .retire_o     (retire_o),
    .retire_pc_o  (retire_pc_o),
    .wb_en_o      (wb_en_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o),
    .halt_o       (halt_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the core stopped retiring", cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // Reference model of the RV32I subset
  function automatic logic signed_less(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return {31'b0, signed_less(a, b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? ((a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh)))
                          : a >> sh;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return signed_less(a, b);
      3'b101:  return !signed_less(a, b);
      3'b110:  return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic model_step(output logic exp_wb, output logic [REG_AW-1:0] exp_rd,
                            output logic [XLEN-1:0] exp_data, output logic exp_halt);
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   next;
    logic [2:0]        f3;
    inst     = prog_mem[model_pc[IMEM_AW+1:2]];
    f3       = inst[14:12];
    a        = model_regs[inst[19:15]];
    b        = model_regs[inst[24:20]];
    imm_i    = {{20{inst[31]}}, inst[31:20]};
    next     = model_pc + 4;
    exp_wb   = 1'b1;
    exp_rd   = inst[11:7];
    exp_data = '0;
    exp_halt = 1'b0;
    case (inst[6:0])
      OPC_OP:     exp_data = alu_model(f3, inst[30], a, b);
      OPC_OP_IMM: exp_data = alu_model(f3, inst[30] && (f3 == 3'b101), a, imm_i);
      OPC_LUI:    exp_data = {inst[31:12], 12'b0};
      OPC_AUIPC:  exp_data = model_pc + {inst[31:12], 12'b0};
      OPC_BRANCH: begin
        exp_wb = 1'b0;
        if (branch_model(f3, a, b)) begin
          next = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        exp_data = model_pc + 4;
        next = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        exp_data = model_pc + 4;
        next = (a + imm_i) & ~32'd1;
      end
      default: begin
        exp_wb   = 1'b0;
        exp_halt = (inst == EBREAK);
      end
    endcase
    if (exp_wb && exp_rd != 0) begin
      model_regs[exp_rd] = exp_data;
    end
    model_pc = next;
    model_halted = exp_halt;
  endtask

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_reg(input string name, input logic [REG_AW-1:0] got,
                             input logic [REG_AW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic emit(input logic [INST_W-1:0] word);
    prog_q.push_back(word);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [XLEN-1:0] value);
    logic [XLEN-1:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd, OPC_LUI));
    emit(i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  // Reset, load, release and follow every retire until halt
  task automatic run_program();
    logic              exp_wb;
    logic [REG_AW-1:0] exp_rd;
    logic [XLEN-1:0]   exp_data;
    logic [XLEN-1:0]   exp_pc;
    logic              exp_halt;
    logic              done;
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < prog_q.size(); i++) begin
      imem_we_i    = 1'b1;
      imem_addr_i  = i;
      imem_wdata_i = prog_q[i];
      prog_mem[i]  = prog_q[i];
      @(negedge clk);
    end
    imem_we_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    compare_bit("halt_o", halt_o, 1'b0);
    compare_bit("retire_o", retire_o, 1'b0);
    compare_bit("wb_en_o", wb_en_o, 1'b0);
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc     = PC_INIT;
    model_halted = 1'b0;
    rst  = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (retire_o) begin
        exp_pc = model_pc;
        model_step(exp_wb, exp_rd, exp_data, exp_halt);
        compare_word("retire_pc_o", retire_pc_o, exp_pc);
        compare_bit("wb_en_o", wb_en_o, exp_wb);
        if (exp_wb) begin
          compare_reg("wb_addr_o", wb_addr_o, exp_rd);
          compare_word("wb_data_o", wb_data_o, exp_data);
        end
        compare_bit("halt_o", halt_o, exp_halt);
      end
      done = halt_o || model_halted;
    end
    if (!model_halted) begin
      errors++;
      $display("Core halted at %0t before the program reached ebreak", $time);
    end
    prog_q.delete();
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("Test %-10s finished: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic test_reg_ops();
    int              c0;
    int              e0;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic [4:0]      rdn;
    c0 = checks;
    e0 = errors;
    for (int r = 0; r < 3; r++) begin
      v1 = next_random();
      v2 = next_random();
      // First round makes slt and sltu disagree and sra fill with ones
      if (r == 0) begin
        v1[XLEN-1] = 1'b1;
        v2[XLEN-1] = 1'b0;
        v2[4]      = 1'b1;
      end
      load_const(5'd1, v1);
      load_const(5'd2, v2);
      for (int k = 0; k < 10; k++) begin
        rdn = k + 3;
        emit(r_type(OP_ALT[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, OP_F3[3*k +: 3], rdn));
      end
    end
    emit(EBREAK);
    run_program();
    report_test("reg_ops", c0, e0);
  endtask

  task automatic test_imm_ops();
    int              c0;
    int              e0;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] rnd;
    logic [4:0]      rdn;
    c0 = checks;
    e0 = errors;
    for (int r = 0; r < 2; r++) begin
      v1 = next_random();
      if (r == 0) begin
        v1[XLEN-1] = 1'b1;
      end
      load_const(5'd1, v1);
      for (int k = 0; k < 6; k++) begin
        rnd = next_random();
        rdn = k + 3;
        emit(i_type(rnd[11:0], 5'd1, IMM_F3[3*k +: 3], rdn, OPC_OP_IMM));
      end
      rnd = next_random();
      emit(i_type({7'h00, rnd[4:0]}, 5'd1, 3'b001, 5'd9, OPC_OP_IMM));
      emit(i_type({7'h00, rnd[9:5]}, 5'd1, 3'b101, 5'd10, OPC_OP_IMM));
      emit(i_type({7'h20, rnd[14:10]}, 5'd1, 3'b101, 5'd11, OPC_OP_IMM));
      emit(u_type(rnd[31:12], 5'd12, OPC_LUI));
      emit(u_type(rnd[31:12], 5'd13, OPC_AUIPC));
      emit(u_type(20'd0, 5'd14, OPC_AUIPC));
    end
    emit(EBREAK);
    run_program();
    report_test("imm_ops", c0, e0);
  endtask

  // A taken branch skips the addi to x5
  task automatic emit_branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
    emit(b_type(13'd8, rs2, rs1, f3));
    emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, OPC_OP_IMM));
    emit(i_type(12'd1, 5'd6, 3'b000, 5'd6, OPC_OP_IMM));
  endtask

  task automatic test_branches();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    load_const(5'd1, 32'hffff_fffb);
    emit(i_type(12'd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    emit(i_type(12'd3, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
    emit_branch_case(3'b000, 5'd2, 5'd3);
    emit_branch_case(3'b000, 5'd1, 5'd2);
    emit_branch_case(3'b001, 5'd1, 5'd2);
    emit_branch_case(3'b001, 5'd2, 5'd3);
    emit_branch_case(3'b100, 5'd1, 5'd2);
    emit_branch_case(3'b100, 5'd2, 5'd1);
    emit_branch_case(3'b101, 5'd2, 5'd1);
    emit_branch_case(3'b101, 5'd1, 5'd2);
    emit_branch_case(3'b110, 5'd2, 5'd1);
    emit_branch_case(3'b110, 5'd1, 5'd2);
    emit_branch_case(3'b111, 5'd1, 5'd2);
    emit_branch_case(3'b111, 5'd2, 5'd1);
    emit(EBREAK);
    run_program();
    report_test("branches", c0, e0);
  endtask

  task automatic test_jumps();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    emit(j_type(21'd12, 5'd1));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
    emit(u_type(20'd0, 5'd2, OPC_AUIPC));
    // Odd offset lands on 24 once bit 0 is cleared
    emit(i_type(12'd13, 5'd2, 3'b000, 5'd3, OPC_JALR));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    emit(j_type(21'd8, 5'd4));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
    emit(EBREAK);
    run_program();
    report_test("jumps", c0, e0);
  endtask

  task automatic test_x0_writes();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
    emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
    emit(u_type(20'h12345, 5'd0, OPC_LUI));
    emit(i_type(12'd7, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    emit(r_type(7'h00, 5'd2, 5'd0, 3'b100, 5'd3));
    emit(EBREAK);
    run_program();
    report_test("x0_writes", c0, e0);
  endtask

  task automatic test_halt_reset();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    load_const(5'd1, next_random());
    load_const(5'd2, next_random());
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(EBREAK);
    run_program();
    repeat (HALT_WAIT) begin
      @(negedge clk);
      if (retire_o) begin
        errors++;
        $display("Core retired an instruction at %0t after it halted", $time);
      end
    end
    compare_bit("halt_o", halt_o, 1'b1);
    // Second program reads registers that reset must have cleared
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(i_type(12'd9, 5'd1, 3'b000, 5'd4, OPC_OP_IMM));
    emit(i_type(12'd1, 5'd2, 3'b110, 5'd5, OPC_OP_IMM));
    emit(EBREAK);
    run_program();
    report_test("halt_reset", c0, e0);
  endtask

  initial begin
    rst          = 1'b1;
    imem_we_i    = 1'b0;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    test_reg_ops();
    test_imm_ops();
    test_branches();
    test_jumps();
    test_x0_writes();
    test_halt_reset();
    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/npc_pkg.sv
verilog/npc_if.sv
verilog/npc_pc.sv
verilog/npc_regfile.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_exu.sv
verilog/npc_top.sv
testbench/npc_tb.sv

// File: Bender.yml
package:
  name: npc

sources:
  - verilog/npc_pkg.sv
  - verilog/npc_if.sv
  - verilog/npc_pc.sv
  - verilog/npc_regfile.sv
  - verilog/npc_ifu.sv
  - verilog/npc_idu.sv
  - verilog/npc_exu.sv
  - verilog/npc_top.sv
  - target: test
    files:
      - testbench/npc_tb.sv
